// ==== common/dcache_pkg.sv ====
// Shared widths and channel structs of the write-through L1 data cache.
// Lines are fixed at four 32-bit words. The number of lines is a module
// parameter, so the index and tag fields are cut from the full address
// inside each module. Byte addresses are always 32 bits wide.
package dcache_pkg;

  localparam int XLEN           = 32;
  localparam int ADDR_W         = 32;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_W         = XLEN * WORDS_PER_LINE;
  localparam int OFF_W          = $clog2(WORDS_PER_LINE);
  localparam int BE_W           = XLEN / 8;
  // address bits below the word offset and below the index
  localparam int BYTE_W         = $clog2(BE_W);
  localparam int LINE_OFF_W     = OFF_W + BYTE_W;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [XLEN-1:0]   word_t;
  typedef logic [LINE_W-1:0] line_t;
  typedef logic [BE_W-1:0]   be_t;

  //////////////////////////////////////////////////
  // core side requests
  //////////////////////////////////////////////////

  typedef struct packed {
    addr_t addr;
  } ld_req_t;

  typedef struct packed {
    addr_t addr;
    word_t data;
    be_t   be;
  } st_req_t;

  // reads are whole aligned lines, writes are single words
  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t data;
    be_t   be;
  } mem_req_t;

  //////////////////////////////////////////////////
  // cache array ports
  //////////////////////////////////////////////////

  typedef struct packed {
    addr_t addr;
  } rd_port_t;

  typedef struct packed {
    logic  hit;
    word_t data;
  } rd_resp_t;

  // valid low invalidates the indexed line
  typedef struct packed {
    addr_t addr;
    line_t data;
    logic  valid;
  } cl_wr_t;

  typedef struct packed {
    addr_t addr;
    word_t data;
    be_t   be;
  } word_wr_t;

endpackage

// ==== design/dcache_mem.sv ====
`timescale 1ns/1ps
// Tag, valid and data arrays of the direct mapped cache.
// One read is granted per cycle, the load port first. No grant is given
// while a line write is in progress. The response comes one cycle after
// the grant and is only meaningful in that cycle.
// A word write lands only if the line still holds the same tag.
module dcache_mem
  import dcache_pkg::*;
#(
  parameter int NumLines = 16
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     ld_rd_req_i,
  input  rd_port_t ld_rd_i,
  output logic     ld_rd_gnt_o,
  output rd_resp_t ld_rd_o,
  input  logic     st_rd_req_i,
  input  rd_port_t st_rd_i,
  output logic     st_rd_gnt_o,
  output rd_resp_t st_rd_o,
  input  logic     cl_wr_vld_i,
  input  cl_wr_t   cl_wr_i,
  input  logic     word_wr_vld_i,
  input  word_wr_t word_wr_i
);

  localparam int IDX_W = $clog2(NumLines);
  localparam int TAG_W = ADDR_W - IDX_W - LINE_OFF_W;

  logic [NumLines-1:0] valid_q;
  logic [TAG_W-1:0]    tag_mem  [NumLines];
  word_t               data_mem [NumLines][WORDS_PER_LINE];

  logic [IDX_W-1:0] cl_idx;
  logic [IDX_W-1:0] wr_idx;
  logic [OFF_W-1:0] wr_off;
  logic             word_hit;

  assign cl_idx = cl_wr_i.addr[LINE_OFF_W +: IDX_W];
  assign wr_idx = word_wr_i.addr[LINE_OFF_W +: IDX_W];
  assign wr_off = word_wr_i.addr[BYTE_W +: OFF_W];

  // a refill of the same index in this cycle wins over the word update
  assign word_hit = valid_q[wr_idx]
                 && (tag_mem[wr_idx] == word_wr_i.addr[ADDR_W-1 -: TAG_W])
                 && !(cl_wr_vld_i && (cl_idx == wr_idx));

  //////////////////////////////////////////////////
  // read arbitration and tag compare
  //////////////////////////////////////////////////

  assign ld_rd_gnt_o = ld_rd_req_i && !cl_wr_vld_i;
  assign st_rd_gnt_o = st_rd_req_i && !ld_rd_req_i && !cl_wr_vld_i;

  function automatic rd_resp_t lookup(input addr_t addr);
    rd_resp_t         resp;
    logic [IDX_W-1:0] idx;
    idx       = addr[LINE_OFF_W +: IDX_W];
    resp.hit  = valid_q[idx] && (tag_mem[idx] == addr[ADDR_W-1 -: TAG_W]);
    resp.data = data_mem[idx][addr[BYTE_W +: OFF_W]];
    return resp;
  endfunction

  always_ff @(posedge clk_i) begin
    if (ld_rd_gnt_o) begin
      ld_rd_o <= lookup(ld_rd_i.addr);
    end
    if (st_rd_gnt_o) begin
      st_rd_o <= lookup(st_rd_i.addr);
    end
  end

  //////////////////////////////////////////////////
  // write ports
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (cl_wr_vld_i) begin
      valid_q[cl_idx] <= cl_wr_i.valid;
    end
  end

  // invalidation only touches the valid bit
  always_ff @(posedge clk_i) begin
    if (cl_wr_vld_i && cl_wr_i.valid) begin
      tag_mem[cl_idx] <= cl_wr_i.addr[ADDR_W-1 -: TAG_W];
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        data_mem[cl_idx][w] <= cl_wr_i.data[w*XLEN +: XLEN];
      end
    end
    if (word_wr_vld_i && word_hit) begin
      for (int b = 0; b < BE_W; b++) begin
        if (word_wr_i.be[b]) begin
          data_mem[wr_idx][wr_off][b*8 +: 8] <= word_wr_i.data[b*8 +: 8];
        end
      end
    end
  end

endmodule

// ==== design/dcache_load_ctrl.sv ====
`timescale 1ns/1ps
// Load port controller. A hit acks three cycles after the request is
// seen: request, grant, response and then ack. With the cache disabled
// every load goes straight to the miss unit.
// ld_ack_o stays high until the core drops ld_req_i.
module dcache_load_ctrl
  import dcache_pkg::*;
#(
  parameter int NumLines = 16
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     cache_en_i,
  input  logic     ld_req_i,
  input  ld_req_t  ld_i,
  output logic     ld_ack_o,
  output word_t    ld_rdata_o,
  output logic     rd_req_o,
  output rd_port_t rd_o,
  input  logic     rd_gnt_i,
  input  rd_resp_t rd_i,
  output logic     miss_req_o,
  output addr_t    miss_addr_o,
  input  logic     miss_ack_i,
  input  line_t    miss_line_i
);

  localparam int IDX_W = $clog2(NumLines);
  localparam int TAG_W = ADDR_W - IDX_W - LINE_OFF_W;

  typedef enum logic [2:0] {
    IDLE,
    READ,
    COMPARE,
    MISS,
    RELEASE,
    ACK
  } state_e;

  state_e           state_q;
  state_e           state_d;
  addr_t            addr_q;
  word_t            rdata_q;
  logic [OFF_W-1:0] off;
  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] tag;

  assign off = addr_q[BYTE_W +: OFF_W];
  assign idx = addr_q[LINE_OFF_W +: IDX_W];
  assign tag = addr_q[ADDR_W-1 -: TAG_W];

  // word address for the lookup, aligned line address for the refill
  assign rd_o.addr   = {tag, idx, off, {BYTE_W{1'b0}}};
  assign miss_addr_o = {tag, idx, {LINE_OFF_W{1'b0}}};

  assign rd_req_o   = (state_q == READ);
  assign miss_req_o = (state_q == MISS);
  assign ld_ack_o   = (state_q == ACK);
  assign ld_rdata_o = rdata_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (ld_req_i) state_d = cache_en_i ? READ : MISS;
      READ:    if (rd_gnt_i) state_d = COMPARE;
      COMPARE: state_d = rd_i.hit ? ACK : MISS;
      MISS:    if (miss_ack_i) state_d = RELEASE;
      RELEASE: if (!miss_ack_i) state_d = ACK;
      ACK:     if (!ld_req_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // pick the requested word out of the refill line
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && ld_req_i) begin
      addr_q <= ld_i.addr;
    end
    if (state_q == COMPARE) begin
      rdata_q <= rd_i.data;
    end
    if (state_q == MISS && miss_ack_i) begin
      rdata_q <= miss_line_i[off*XLEN +: XLEN];
    end
  end

endmodule

// ==== design/dcache_store_ctrl.sv ====
`timescale 1ns/1ps
// Store port controller. Every store is written through to memory.
// A store miss never allocates a line.
// Stores issued while the cache is disabled do not update cached lines,
// so the cache should be flushed before it is enabled again.
// st_ack_o stays high until the core drops st_req_i.
module dcache_store_ctrl
  import dcache_pkg::*;
#(
  parameter int NumLines = 16
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     cache_en_i,
  input  logic     st_req_i,
  input  st_req_t  st_i,
  output logic     st_ack_o,
  output logic     rd_req_o,
  output rd_port_t rd_o,
  input  logic     rd_gnt_i,
  input  rd_resp_t rd_i,
  output logic     wr_req_o,
  output st_req_t  wr_o,
  input  logic     wr_ack_i,
  output logic     word_wr_vld_o,
  output word_wr_t word_wr_o
);

  localparam int IDX_W = $clog2(NumLines);
  localparam int TAG_W = ADDR_W - IDX_W - LINE_OFF_W;

  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    WDONE,
    READ,
    COMPARE,
    UPDATE,
    ACK
  } state_e;

  state_e  state_q;
  state_e  state_d;
  st_req_t st_q;

  assign rd_o.addr = {st_q.addr[ADDR_W-1 -: TAG_W],
                      st_q.addr[LINE_OFF_W +: IDX_W],
                      st_q.addr[BYTE_W +: OFF_W],
                      {BYTE_W{1'b0}}};

  assign wr_o     = st_q;
  assign wr_req_o = (state_q == WRITE);
  assign rd_req_o = (state_q == READ);
  assign st_ack_o = (state_q == ACK);

  assign word_wr_vld_o  = (state_q == UPDATE);
  assign word_wr_o.addr = st_q.addr;
  assign word_wr_o.data = st_q.data;
  assign word_wr_o.be   = st_q.be;

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////

  // the tag is checked only once memory holds the new data, so a refill
  // that raced with this store cannot leave a stale word behind
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (st_req_i) state_d = WRITE;
      WRITE:   if (wr_ack_i) state_d = WDONE;
      WDONE:   if (!wr_ack_i) state_d = cache_en_i ? READ : ACK;
      READ:    if (rd_gnt_i) state_d = COMPARE;
      COMPARE: state_d = rd_i.hit ? UPDATE : ACK;
      UPDATE:  state_d = ACK;
      ACK:     if (!st_req_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && st_req_i) begin
      st_q <= st_i;
    end
  end

endmodule

// ==== design/dcache_missunit.sv ====
`timescale 1ns/1ps
// Miss unit. Owns the single memory port and the line write port.
// Priority is flush, then load refill, then store write-through. A flush
// starts only while both controllers are idle and then invalidates one
// index per cycle. The registered enable changes only while the unit is
// idle. Refills are allocated only with the cache enabled.
module dcache_missunit
  import dcache_pkg::*;
#(
  parameter int NumLines = 16
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     enable_i,
  input  logic     flush_i,
  output logic     flush_ack_o,
  output logic     miss_o,
  output logic     cache_en_o,
  input  logic     ld_busy_i,
  input  logic     st_busy_i,
  input  logic     ld_miss_req_i,
  input  addr_t    ld_miss_addr_i,
  output logic     ld_miss_ack_o,
  output line_t    ld_miss_line_o,
  input  logic     st_wr_req_i,
  input  st_req_t  st_wr_i,
  output logic     st_wr_ack_o,
  output logic     cl_wr_vld_o,
  output cl_wr_t   cl_wr_o,
  output logic     mem_req_o,
  output mem_req_t mem_o,
  input  logic     mem_ack_i,
  input  line_t    mem_rdata_i
);

  localparam int IDX_W = $clog2(NumLines);

  typedef enum logic [2:0] {
    IDLE,
    FLUSH,
    LD_MEM,
    LD_RET,
    ST_MEM,
    ST_RET
  } state_e;

  state_e           state_q;
  state_e           state_d;
  logic             cache_en_q;
  logic             miss_q;
  logic             flush_ack_q;
  logic [IDX_W-1:0] flush_cnt_q;
  line_t            line_q;
  logic             flush_go;
  logic             flush_last;
  addr_t            ld_line_addr;
  addr_t            flush_addr;

  // flush_ack_q keeps a still-high flush_i from starting a second sweep
  assign flush_go   = flush_i && !flush_ack_q && !ld_busy_i && !st_busy_i;
  assign flush_last = &flush_cnt_q;

  assign ld_line_addr = {ld_miss_addr_i[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};

  always_comb begin
    flush_addr = '0;
    flush_addr[LINE_OFF_W +: IDX_W] = flush_cnt_q;
  end

  //////////////////////////////////////////////////
  // arbitration and handshakes
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (flush_go) state_d = FLUSH;
        else if (ld_miss_req_i) state_d = LD_MEM;
        else if (st_wr_req_i) state_d = ST_MEM;
      end
      FLUSH:   if (flush_last) state_d = IDLE;
      LD_MEM:  if (mem_ack_i) state_d = LD_RET;
      LD_RET:  if (!ld_miss_req_i && !mem_ack_i) state_d = IDLE;
      ST_MEM:  if (mem_ack_i) state_d = ST_RET;
      ST_RET:  if (!st_wr_req_i && !mem_ack_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      cache_en_q  <= 1'b0;
      miss_q      <= 1'b0;
      flush_ack_q <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      miss_q      <= (state_q != LD_MEM) && (state_d == LD_MEM);
      flush_ack_q <= (state_q == FLUSH) && flush_last;
      if (state_q == IDLE) begin
        cache_en_q <= enable_i;
      end
      if (state_q == FLUSH) begin
        flush_cnt_q <= flush_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == LD_MEM && mem_ack_i) begin
      line_q <= mem_rdata_i;
    end
  end

  assign cache_en_o     = cache_en_q;
  assign miss_o         = miss_q;
  assign flush_ack_o    = flush_ack_q;
  assign ld_miss_ack_o  = (state_q == LD_RET);
  assign ld_miss_line_o = line_q;
  assign st_wr_ack_o    = (state_q == ST_RET);

  //////////////////////////////////////////////////
  // memory port and line writes
  //////////////////////////////////////////////////

  assign mem_req_o = (state_q == LD_MEM) || (state_q == ST_MEM);

  always_comb begin
    mem_o = '0;
    if (state_q == ST_MEM) begin
      mem_o.we   = 1'b1;
      mem_o.addr = st_wr_i.addr;
      mem_o.data = st_wr_i.data;
      mem_o.be   = st_wr_i.be;
    end else begin
      mem_o.addr = ld_line_addr;
    end
  end

  // refill data goes into the array in the cycle memory acks
  assign cl_wr_vld_o = (state_q == FLUSH) || (state_q == LD_MEM && mem_ack_i && cache_en_q);

  always_comb begin
    if (state_q == FLUSH) begin
      cl_wr_o.addr  = flush_addr;
      cl_wr_o.data  = '0;
      cl_wr_o.valid = 1'b0;
    end else begin
      cl_wr_o.addr  = ld_line_addr;
      cl_wr_o.data  = mem_rdata_i;
      cl_wr_o.valid = 1'b1;
    end
  end

endmodule

// ==== design/wt_dcache.sv ====
`timescale 1ns/1ps
// Write-through L1 data cache, direct mapped, four words per line.
// All core and memory channels use a four-phase req/ack handshake.
// NumLines must be a power of two, at least 2.
module wt_dcache
  import dcache_pkg::*;
#(
  parameter int NumLines = 16
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     enable_i,
  input  logic     flush_i,
  output logic     flush_ack_o,
  output logic     miss_o,
  input  logic     ld_req_i,
  input  ld_req_t  ld_i,
  output logic     ld_ack_o,
  output word_t    ld_rdata_o,
  input  logic     st_req_i,
  input  st_req_t  st_i,
  output logic     st_ack_o,
  output logic     mem_req_o,
  output mem_req_t mem_o,
  input  logic     mem_ack_i,
  input  line_t    mem_rdata_i
);

  logic     cache_en;
  logic     ld_busy;
  logic     st_busy;
  logic     ld_rd_req;
  logic     ld_rd_gnt;
  rd_port_t ld_rd;
  rd_resp_t ld_rd_resp;
  logic     st_rd_req;
  logic     st_rd_gnt;
  rd_port_t st_rd;
  rd_resp_t st_rd_resp;
  logic     ld_miss_req;
  addr_t    ld_miss_addr;
  logic     ld_miss_ack;
  line_t    ld_miss_line;
  logic     st_wr_req;
  st_req_t  st_wr;
  logic     st_wr_ack;
  logic     cl_wr_vld;
  cl_wr_t   cl_wr;
  logic     word_wr_vld;
  word_wr_t word_wr;

  // a controller is busy from request until its ack is dropped
  assign ld_busy = ld_req_i || ld_ack_o;
  assign st_busy = st_req_i || st_ack_o;

  dcache_mem #(.NumLines(NumLines)) u_mem (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .ld_rd_req_i(ld_rd_req), .ld_rd_i(ld_rd), .ld_rd_gnt_o(ld_rd_gnt), .ld_rd_o(ld_rd_resp),
    .st_rd_req_i(st_rd_req), .st_rd_i(st_rd), .st_rd_gnt_o(st_rd_gnt), .st_rd_o(st_rd_resp),
    .cl_wr_vld_i(cl_wr_vld), .cl_wr_i(cl_wr),
    .word_wr_vld_i(word_wr_vld), .word_wr_i(word_wr)
  );

  dcache_load_ctrl #(.NumLines(NumLines)) u_load_ctrl (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .cache_en_i(cache_en),
    .ld_req_i(ld_req_i), .ld_i(ld_i), .ld_ack_o(ld_ack_o), .ld_rdata_o(ld_rdata_o),
    .rd_req_o(ld_rd_req), .rd_o(ld_rd), .rd_gnt_i(ld_rd_gnt), .rd_i(ld_rd_resp),
    .miss_req_o(ld_miss_req), .miss_addr_o(ld_miss_addr),
    .miss_ack_i(ld_miss_ack), .miss_line_i(ld_miss_line)
  );

  dcache_store_ctrl #(.NumLines(NumLines)) u_store_ctrl (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .cache_en_i(cache_en),
    .st_req_i(st_req_i), .st_i(st_i), .st_ack_o(st_ack_o),
    .rd_req_o(st_rd_req), .rd_o(st_rd), .rd_gnt_i(st_rd_gnt), .rd_i(st_rd_resp),
    .wr_req_o(st_wr_req), .wr_o(st_wr), .wr_ack_i(st_wr_ack),
    .word_wr_vld_o(word_wr_vld), .word_wr_o(word_wr)
  );

  dcache_missunit #(.NumLines(NumLines)) u_missunit (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .enable_i(enable_i),
    .flush_i(flush_i), .flush_ack_o(flush_ack_o), .miss_o(miss_o), .cache_en_o(cache_en),
    .ld_busy_i(ld_busy), .st_busy_i(st_busy),
    .ld_miss_req_i(ld_miss_req), .ld_miss_addr_i(ld_miss_addr),
    .ld_miss_ack_o(ld_miss_ack), .ld_miss_line_o(ld_miss_line),
    .st_wr_req_i(st_wr_req), .st_wr_i(st_wr), .st_wr_ack_o(st_wr_ack),
    .cl_wr_vld_o(cl_wr_vld), .cl_wr_o(cl_wr),
    .mem_req_o(mem_req_o), .mem_o(mem_o), .mem_ack_i(mem_ack_i), .mem_rdata_i(mem_rdata_i)
  );

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps
// Free running clock with a 4 ns period.
// Reset is active low and released on the fifth rising edge.
module tb_clock #(
  parameter int HalfPeriodNs = 2,
  parameter int ResetCycles  = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriodNs) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== bench/tb_wt_dcache.sv ====
`timescale 1ns/1ps
// Directed testbench for the write-through data cache.
// Memory holds 64 lines at byte addresses 0 to 0x3ff and answers each
// request one to four cycles after it is seen. Expected load data comes
// from a shadow copy of memory that merges every store by byte enables.
module tb_wt_dcache
  import dcache_pkg::*;
();

  localparam int NUM_LINES  = 16;
  localparam int MEM_WORDS  = 256;
  // about 230 operations of at most 20 cycles each, with wide margin
  localparam int MAX_CYCLES = 20000;
  localparam int SEED       = 32'h85c2;

  logic     clk_i;
  logic     rst_n_i;
  logic     enable_i;
  logic     flush_i;
  logic     flush_ack_o;
  logic     miss_o;
  logic     ld_req_i;
  ld_req_t  ld_i;
  logic     ld_ack_o;
  word_t    ld_rdata_o;
  logic     st_req_i;
  st_req_t  st_i;
  logic     st_ack_o;
  logic     mem_req_o;
  mem_req_t mem_o;
  logic     mem_ack_i   = 1'b0;
  line_t    mem_rdata_i = '0;

  word_t    mem_words [MEM_WORDS];
  word_t    shadow    [MEM_WORDS];
  integer   stim_seed  = SEED;
  integer   delay_seed = SEED;
  logic     mem_armed;
  int       mem_wait;
  int       read_cnt;
  int       miss_cnt;
  int       cycle_cnt  = 0;
  int       errors     = 0;
  int       checks     = 0;

  tb_clock u_clock (.clk_o(clk_i), .rst_n_o(rst_n_i));

  wt_dcache #(.NumLines(NUM_LINES)) UUT (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .enable_i(enable_i),
    .flush_i(flush_i), .flush_ack_o(flush_ack_o), .miss_o(miss_o),
    .ld_req_i(ld_req_i), .ld_i(ld_i), .ld_ack_o(ld_ack_o), .ld_rdata_o(ld_rdata_o),
    .st_req_i(st_req_i), .st_i(st_i), .st_ack_o(st_ack_o),
    .mem_req_o(mem_req_o), .mem_o(mem_o), .mem_ack_i(mem_ack_i), .mem_rdata_i(mem_rdata_i)
  );

  // initial contents depend on the whole byte address
  function automatic word_t fill_word(input logic [7:0] idx);
    addr_t a;
    a = {22'd0, idx, 2'b00};
    return {~a[15:0], a[15:0]};
  endfunction

  function automatic word_t merge_bytes(input word_t old, input word_t data, input be_t be);
    word_t res;
    res = old;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return res;
  endfunction

  //////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////

  always @(posedge clk_i or negedge rst_n_i) begin : mem_model
    logic [7:0] widx;
    line_t      line;
    if (!rst_n_i) begin
      mem_ack_i <= 1'b0;
      mem_armed <= 1'b0;
      mem_wait  <= 0;
      read_cnt  <= 0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_words[i] <= fill_word(i[7:0]);
      end
    end else if (mem_ack_i) begin
      if (!mem_req_o) begin
        mem_ack_i <= 1'b0;
      end
    end else if (mem_req_o) begin
      widx = mem_o.addr[9:2];
      if (!mem_armed) begin
        mem_armed <= 1'b1;
        mem_wait  <= $random(delay_seed) & 3;
      end else if (mem_wait != 0) begin
        mem_wait <= mem_wait - 1;
      end else begin
        mem_armed <= 1'b0;
        mem_ack_i <= 1'b1;
        if (mem_o.we) begin
          mem_words[widx] <= merge_bytes(mem_words[widx], mem_o.data, mem_o.be);
        end else begin
          for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[w*XLEN +: XLEN] = mem_words[{widx[7:2], w[1:0]}];
          end
          mem_rdata_i <= line;
          read_cnt    <= read_cnt + 1;
        end
      end
    end
  end

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      miss_cnt <= 0;
    end else if (miss_o) begin
      miss_cnt <= miss_cnt + 1;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // drivers and checks
  //////////////////////////////////////////////////

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic load_word(input addr_t addr, output word_t data);
    @(posedge clk_i);
    ld_req_i  <= 1'b1;
    ld_i.addr <= addr;
    do @(posedge clk_i); while (!ld_ack_o);
    data = ld_rdata_o;
    ld_req_i <= 1'b0;
    do @(posedge clk_i); while (ld_ack_o);
  endtask

  task automatic store_word(input addr_t addr, input word_t data, input be_t be);
    @(posedge clk_i);
    st_req_i  <= 1'b1;
    st_i.addr <= addr;
    st_i.data <= data;
    st_i.be   <= be;
    do @(posedge clk_i); while (!st_ack_o);
    st_req_i <= 1'b0;
    shadow[addr[9:2]] = merge_bytes(shadow[addr[9:2]], data, be);
    do @(posedge clk_i); while (st_ack_o);
  endtask

  // load, then check data, memory reads and miss pulses against the rules
  task automatic load_check(input addr_t addr, input int reads, input int misses);
    int    r0;
    int    m0;
    word_t got;
    r0 = read_cnt;
    m0 = miss_cnt;
    load_word(addr, got);
    check_word("ld_rdata_o", got, shadow[addr[9:2]]);
    check_word("memory read count", word_t'(read_cnt - r0), word_t'(reads));
    check_word("miss_o pulse count", word_t'(miss_cnt - m0), word_t'(misses));
  endtask

  // flush_ack_o is a single cycle pulse
  task automatic flush_cache();
    @(posedge clk_i);
    flush_i <= 1'b1;
    do @(posedge clk_i); while (!flush_ack_o);
    flush_i <= 1'b0;
    @(posedge clk_i);
    check_word("flush_ack_o", word_t'(flush_ack_o), '0);
  endtask

  // the enable register follows enable_i on the next idle cycle
  task automatic set_enable(input logic en);
    @(posedge clk_i);
    enable_i <= en;
    repeat (2) @(posedge clk_i);
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  // miss then hit on the same line
  task automatic miss_then_hit();
    load_check(32'h104, 1, 1);
    load_check(32'h10c, 0, 0);
  endtask

  task automatic store_hit_merge();
    word_t old;
    old = fill_word(8'h42);
    store_word(32'h108, 32'hdeadbeef, 4'b0110);
    check_word("mem_words[0x42]", mem_words[8'h42], {old[31:24], 16'hadbe, old[7:0]});
    load_check(32'h108, 0, 0);
  endtask

  // store miss leaves the line uncached
  task automatic store_miss_no_alloc();
    store_word(32'h2a0, 32'h12345678, 4'hf);
    load_check(32'h2a0, 1, 1);
  endtask

  // both lines were cached before the flush
  task automatic flush_invalidates();
    flush_cache();
    load_check(32'h104, 1, 1);
    load_check(32'h2a0, 1, 1);
  endtask

  // bypass allocates nothing
  task automatic bypass_no_alloc();
    set_enable(1'b0);
    load_check(32'h330, 1, 1);
    load_check(32'h330, 1, 1);
    set_enable(1'b1);
    load_check(32'h330, 1, 1);
    load_check(32'h330, 0, 0);
  endtask

  task automatic random_mix();
    word_t rnd;
    word_t data;
    word_t got;
    addr_t addr;
    for (int n = 0; n < 200; n++) begin
      rnd  = $random(stim_seed);
      data = $random(stim_seed);
      addr = {22'd0, rnd[9:2], 2'b00};
      if (rnd[16]) begin
        store_word(addr, data, rnd[13:10]);
      end else begin
        load_word(addr, got);
        check_word("ld_rdata_o", got, shadow[addr[9:2]]);
      end
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_word("mem_words", mem_words[i], shadow[i]);
    end
  endtask

  initial begin
    enable_i <= 1'b1;
    flush_i  <= 1'b0;
    ld_req_i <= 1'b0;
    ld_i     <= '0;
    st_req_i <= 1'b0;
    st_i     <= '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = fill_word(i[7:0]);
    end
    wait (rst_n_i === 1'b1);
    repeat (2) @(posedge clk_i);

    miss_then_hit();
    store_hit_merge();
    store_miss_no_alloc();
    flush_invalidates();
    bypass_no_alloc();
    random_mix();

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
common/dcache_pkg.sv
design/dcache_mem.sv
design/dcache_load_ctrl.sv
design/dcache_store_ctrl.sv
design/dcache_missunit.sv
design/wt_dcache.sv
bench/tb_clock.sv
bench/tb_wt_dcache.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the cache testbench with Verilator, run it and scan the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module tb_wt_dcache -o sim_tb_wt_dcache

./obj_dir/sim_tb_wt_dcache > sim.log 2>&1
cat sim.log

if grep -q "Verification failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if ! grep -q "Verification passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
